// ==== hw/simd_alu_config.svh ====
`ifndef SIMD_ALU_CONFIG_SVH
`define SIMD_ALU_CONFIG_SVH

// ********************
// datapath sizing
// ********************

// operand and result width
`define SIMD_ALU_XLEN 64

// opcode field, six bits as in the vector isa
`define SIMD_ALU_OP_W 6

// lane counts per width code
`define SIMD_ALU_N_B 8   // 00 bytes
`define SIMD_ALU_N_H 4   // 01 half-words
`define SIMD_ALU_N_W 2   // 10 words
                         // 11 is the single double-word

// shift amount field at double-word width
// narrower lanes take 3, 4 or 5 low bits
`define SIMD_ALU_SHAMT_W 6

`endif

// ==== hw/simd_alu_pkg.sv ====
`include "simd_alu_config.svh"
`default_nettype none

package simd_alu_pkg;

    // ********************
    // opcodes and widths
    // ********************

    // isa encodings, gaps decode to zero
    typedef enum logic [`SIMD_ALU_OP_W-1:0] {
        VAND   = 6'd1,
        VOR    = 6'd2,
        VXOR   = 6'd3,
        VNOT   = 6'd4,
        VADD   = 6'd6,
        VSUB   = 6'd7,
        VMULEU = 6'd8,    // even lanes
        VMULOU = 6'd9,    // odd lanes
        VSLL   = 6'd10,
        VSRL   = 6'd11,
        VRTTH  = 6'd13,   // swap lane halves
        VSQEU  = 6'd16,
        VSQOU  = 6'd17,
        VNOP   = 6'd23
    } alu_op_e;

    typedef enum logic [1:0] {
        LW_BYTE  = 2'b00,
        LW_HALF  = 2'b01,
        LW_WORD  = 2'b10,
        LW_DWORD = 2'b11
    } lane_width_e;

    // one word, four lane views, lane 0 at the msb end
    typedef union packed {
        logic [0:`SIMD_ALU_N_B-1][7:0]  b;
        logic [0:`SIMD_ALU_N_H-1][15:0] h;
        logic [0:`SIMD_ALU_N_W-1][31:0] w;
        logic [`SIMD_ALU_XLEN-1:0]      d;
    } simd_word_u;

    // ********************
    // stage control
    // ********************

    typedef enum logic [1:0] {
        U_LOGIC_ARITH = 2'd0,
        U_MUL         = 2'd1,
        U_SHIFT_ROT   = 2'd2,
        U_ZERO        = 2'd3
    } unit_e;

    typedef enum logic [1:0] {
        LS_AND = 2'd0,
        LS_OR  = 2'd1,
        LS_XOR = 2'd2,
        LS_NOT = 2'd3
    } logic_sel_e;

    typedef struct packed {
        logic        valid;
        unit_e       unit;
        lane_width_e width;
        logic_sel_e  logic_sel;
        logic        arith;    // adder path instead of bitwise
        logic        sub;      // invert b, carry in per lane
        logic        odd;      // odd lane of each pair
        logic        square;   // a used for both factors
        logic        right;    // logical right shift
        logic        rotate;   // half swap, ignores b
    } exec_ctl_t;

endpackage

`default_nettype wire

// ==== hw/simd_alu_decode.sv ====
`timescale 1ns/100ps
`include "simd_alu_config.svh"
`default_nettype none

module simd_alu_decode (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      alu,        // issue strobe
    input  simd_alu_pkg::alu_op_e          alu_op,
    input  simd_alu_pkg::lane_width_e      width,
    input  wire logic [`SIMD_ALU_XLEN-1:0] reg_a_data,
    input  wire logic [`SIMD_ALU_XLEN-1:0] reg_b_data,
    output simd_alu_pkg::exec_ctl_t        ctl,
    output simd_alu_pkg::simd_word_u       op_a,
    output simd_alu_pkg::simd_word_u       op_b
);

    simd_alu_pkg::exec_ctl_t dec;   // next control word

    // ********************
    // opcode decode
    // ********************
    always_comb begin
        dec       = '0;
        dec.valid = 1'b1;
        dec.width = width;
        dec.unit  = simd_alu_pkg::U_ZERO;    // nop and holes
        case (alu_op)
            simd_alu_pkg::VAND: begin
                dec.unit      = simd_alu_pkg::U_LOGIC_ARITH;
                dec.logic_sel = simd_alu_pkg::LS_AND;
            end
            simd_alu_pkg::VOR: begin
                dec.unit      = simd_alu_pkg::U_LOGIC_ARITH;
                dec.logic_sel = simd_alu_pkg::LS_OR;
            end
            simd_alu_pkg::VXOR: begin
                dec.unit      = simd_alu_pkg::U_LOGIC_ARITH;
                dec.logic_sel = simd_alu_pkg::LS_XOR;
            end
            simd_alu_pkg::VNOT: begin
                dec.unit      = simd_alu_pkg::U_LOGIC_ARITH;
                dec.logic_sel = simd_alu_pkg::LS_NOT;
            end
            simd_alu_pkg::VADD, simd_alu_pkg::VSUB: begin
                dec.unit  = simd_alu_pkg::U_LOGIC_ARITH;
                dec.arith = 1'b1;
                dec.sub   = (alu_op == simd_alu_pkg::VSUB);
            end
            simd_alu_pkg::VMULEU, simd_alu_pkg::VMULOU,
            simd_alu_pkg::VSQEU, simd_alu_pkg::VSQOU: begin
                // no double-word product slot, so 11 gives zero
                if (width != simd_alu_pkg::LW_DWORD) begin
                    dec.unit = simd_alu_pkg::U_MUL;
                end
                dec.odd    = (alu_op == simd_alu_pkg::VMULOU) || (alu_op == simd_alu_pkg::VSQOU);
                dec.square = (alu_op == simd_alu_pkg::VSQEU) || (alu_op == simd_alu_pkg::VSQOU);
            end
            simd_alu_pkg::VSLL, simd_alu_pkg::VSRL, simd_alu_pkg::VRTTH: begin
                dec.unit   = simd_alu_pkg::U_SHIFT_ROT;
                dec.right  = (alu_op == simd_alu_pkg::VSRL);
                dec.rotate = (alu_op == simd_alu_pkg::VRTTH);
            end
            default: ;
        endcase
    end

    // ********************
    // stage 1 registers
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctl <= '0;
        end else if (alu) begin
            ctl <= dec;
        end else begin
            ctl.valid <= 1'b0;   // flags hold, nothing issued
        end
    end

    always_ff @(posedge clk) begin
        if (alu) begin
            op_a.d <= reg_a_data;
            op_b.d <= reg_b_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/simd_alu_lane_arith.sv ====
`timescale 1ns/100ps
`include "simd_alu_config.svh"
`default_nettype none

module simd_alu_lane_arith (
    input  simd_alu_pkg::exec_ctl_t  ctl,
    input  simd_alu_pkg::simd_word_u op_a,
    input  simd_alu_pkg::simd_word_u op_b,
    output simd_alu_pkg::simd_word_u arith_res
);

    logic [0:`SIMD_ALU_N_B-1] lane_lsb;    // byte closes its lane
    simd_alu_pkg::simd_word_u b_in;       // b or ~b
    simd_alu_pkg::simd_word_u sum;
    simd_alu_pkg::simd_word_u bit_res;
    logic                     carry;      // ripple between bytes

    // ********************
    // lane boundaries
    // ********************
    // byte i is a lane lsb when i+1 is a multiple of the lane's byte count
    always_comb begin
        for (int i = 0; i < `SIMD_ALU_N_B; i++) begin
            lane_lsb[i] = (((i + 1) & ((1 << ctl.width) - 1)) == 0);
        end
    end

    // ********************
    // lane-wise add / sub
    // ********************
    // one byte-sliced adder shared by all widths
    // carry is cut at each lane lsb and reloaded with sub
    always_comb begin
        b_in.d = ctl.sub ? ~op_b.d : op_b.d;   // a + ~b + 1 per lane
        carry  = ctl.sub;
        // walk from the lsb byte (lane 7) up to byte 0
        for (int i = `SIMD_ALU_N_B - 1; i >= 0; i--) begin
            if (lane_lsb[i]) begin
                carry = ctl.sub;               // fresh lane
            end
            {carry, sum.b[i]} = {1'b0, op_a.b[i]} + {1'b0, b_in.b[i]} + carry;
        end
        // carry out of the top byte is dropped, lanes wrap
    end

    // ********************
    // bitwise ops
    // ********************
    // width has no effect here
    always_comb begin
        case (ctl.logic_sel)
            simd_alu_pkg::LS_AND: bit_res.d = op_a.d & op_b.d;
            simd_alu_pkg::LS_OR:  bit_res.d = op_a.d | op_b.d;
            simd_alu_pkg::LS_XOR: bit_res.d = op_a.d ^ op_b.d;
            simd_alu_pkg::LS_NOT: bit_res.d = ~op_a.d;          // b unused
            default:              bit_res.d = '0;
        endcase
    end

    assign arith_res = ctl.arith ? sum : bit_res;

endmodule

`default_nettype wire

// ==== hw/simd_alu_lane_mul.sv ====
`timescale 1ns/100ps
`include "simd_alu_config.svh"
`default_nettype none

module simd_alu_lane_mul (
    input  simd_alu_pkg::exec_ctl_t  ctl,
    input  simd_alu_pkg::simd_word_u op_a,
    input  simd_alu_pkg::simd_word_u op_b,
    output simd_alu_pkg::simd_word_u mul_res
);

    simd_alu_pkg::simd_word_u fac_b;   // second factor

    // square reuses a for both factors
    assign fac_b = ctl.square ? op_a : op_b;

    // ********************
    // even / odd multiply
    // ********************
    // lanes pair up as (0,1) (2,3) ...
    // pair k picks lane 2k or 2k+1 and its
    // product fills double-width slot k
    always_comb begin
        mul_res = '0;
        case (ctl.width)
            simd_alu_pkg::LW_BYTE: begin
                // four 8x8 into half-word slots
                for (int k = 0; k < `SIMD_ALU_N_H; k++) begin
                    mul_res.h[k] = op_a.b[2*k + ctl.odd] * fac_b.b[2*k + ctl.odd];
                end
            end
            simd_alu_pkg::LW_HALF: begin
                // two 16x16 into word slots
                for (int k = 0; k < `SIMD_ALU_N_W; k++) begin
                    mul_res.w[k] = op_a.h[2*k + ctl.odd] * fac_b.h[2*k + ctl.odd];
                end
            end
            simd_alu_pkg::LW_WORD: begin
                // one 32x32, full 64 bit product
                mul_res.d = op_a.w[ctl.odd] * fac_b.w[ctl.odd];
            end
            default: begin
                mul_res = '0;   // 11 never issued here, decode zeroes it
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/simd_alu_shift_rot.sv ====
`timescale 1ns/100ps
`include "simd_alu_config.svh"
`default_nettype none

module simd_alu_shift_rot (
    input  simd_alu_pkg::exec_ctl_t  ctl,
    input  simd_alu_pkg::simd_word_u op_a,
    input  simd_alu_pkg::simd_word_u op_b,
    output simd_alu_pkg::simd_word_u shift_res
);

    logic [`SIMD_ALU_SHAMT_W-1:0] shamt_d;   // double-word amount

    assign shamt_d = op_b.d[`SIMD_ALU_SHAMT_W-1:0];

    // ********************
    // per-lane shift
    // ********************
    // amount comes from the low bits of the same lane of b
    // zero fill, nothing crosses a lane
    // rotate ignores b and swaps lane halves
    always_comb begin
        shift_res = '0;
        case (ctl.width)
            simd_alu_pkg::LW_BYTE: begin
                for (int i = 0; i < `SIMD_ALU_N_B; i++) begin
                    if (ctl.rotate) begin
                        shift_res.b[i] = {op_a.b[i][3:0], op_a.b[i][7:4]};   // nibble swap
                    end else if (ctl.right) begin
                        shift_res.b[i] = op_a.b[i] >> op_b.b[i][2:0];
                    end else begin
                        shift_res.b[i] = op_a.b[i] << op_b.b[i][2:0];
                    end
                end
            end
            simd_alu_pkg::LW_HALF: begin
                for (int i = 0; i < `SIMD_ALU_N_H; i++) begin
                    if (ctl.rotate) begin
                        shift_res.h[i] = {op_a.h[i][7:0], op_a.h[i][15:8]};
                    end else if (ctl.right) begin
                        shift_res.h[i] = op_a.h[i] >> op_b.h[i][3:0];
                    end else begin
                        shift_res.h[i] = op_a.h[i] << op_b.h[i][3:0];
                    end
                end
            end
            simd_alu_pkg::LW_WORD: begin
                for (int i = 0; i < `SIMD_ALU_N_W; i++) begin
                    if (ctl.rotate) begin
                        shift_res.w[i] = {op_a.w[i][15:0], op_a.w[i][31:16]};
                    end else if (ctl.right) begin
                        shift_res.w[i] = op_a.w[i] >> op_b.w[i][4:0];
                    end else begin
                        shift_res.w[i] = op_a.w[i] << op_b.w[i][4:0];
                    end
                end
            end
            default: begin
                // single 64 bit lane
                if (ctl.rotate) begin
                    shift_res.d = {op_a.d[31:0], op_a.d[63:32]};
                end else if (ctl.right) begin
                    shift_res.d = op_a.d >> shamt_d;
                end else begin
                    shift_res.d = op_a.d << shamt_d;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/simd_alu_result_sel.sv ====
`timescale 1ns/100ps
`include "simd_alu_config.svh"
`default_nettype none

module simd_alu_result_sel (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  simd_alu_pkg::exec_ctl_t         ctl,
    input  simd_alu_pkg::simd_word_u        arith_res,
    input  simd_alu_pkg::simd_word_u        mul_res,
    input  simd_alu_pkg::simd_word_u        shift_res,
    output logic [`SIMD_ALU_XLEN-1:0]       alu_out,
    output logic                            result_valid
);

    simd_alu_pkg::simd_word_u sel_res;   // chosen unit result

    // unit mux, zero for nop / holes / mul at 11
    always_comb begin
        case (ctl.unit)
            simd_alu_pkg::U_LOGIC_ARITH: sel_res = arith_res;
            simd_alu_pkg::U_MUL:         sel_res = mul_res;
            simd_alu_pkg::U_SHIFT_ROT:   sel_res = shift_res;
            default:                     sel_res = '0;
        endcase
    end

    // ********************
    // stage 2 registers
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_out      <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= ctl.valid;     // one pulse per issue
            if (ctl.valid) begin
                alu_out <= sel_res.d;      // holds between results
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/simd_alu.sv ====
`timescale 1ns/100ps
`include "simd_alu_config.svh"
`default_nettype none

module simd_alu (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       alu,          // issue strobe
    input  simd_alu_pkg::alu_op_e           alu_op,
    input  simd_alu_pkg::lane_width_e       width,
    input  wire logic [`SIMD_ALU_XLEN-1:0]  reg_a_data,
    input  wire logic [`SIMD_ALU_XLEN-1:0]  reg_b_data,
    output logic [`SIMD_ALU_XLEN-1:0]       alu_out,
    output logic                            result_valid
);

    simd_alu_pkg::exec_ctl_t  ctl;       // stage 1 control
    simd_alu_pkg::simd_word_u op_a;
    simd_alu_pkg::simd_word_u op_b;
    simd_alu_pkg::simd_word_u arith_res;
    simd_alu_pkg::simd_word_u mul_res;
    simd_alu_pkg::simd_word_u shift_res;

    // stage 1, operand capture and decode
    simd_alu_decode i_decode (
        .clk(clk), .rst_n(rst_n), .alu(alu), .alu_op(alu_op), .width(width),
        .reg_a_data(reg_a_data), .reg_b_data(reg_b_data),
        .ctl(ctl), .op_a(op_a), .op_b(op_b)
    );

    // execute units, all combinational and in parallel
    simd_alu_lane_arith i_lane_arith (
        .ctl(ctl), .op_a(op_a), .op_b(op_b), .arith_res(arith_res)
    );

    simd_alu_lane_mul i_lane_mul (
        .ctl(ctl), .op_a(op_a), .op_b(op_b), .mul_res(mul_res)
    );

    simd_alu_shift_rot i_shift_rot (
        .ctl(ctl), .op_a(op_a), .op_b(op_b), .shift_res(shift_res)
    );

    // stage 2, select and register
    simd_alu_result_sel i_result_sel (
        .clk(clk), .rst_n(rst_n), .ctl(ctl),
        .arith_res(arith_res), .mul_res(mul_res), .shift_res(shift_res),
        .alu_out(alu_out), .result_valid(result_valid)
    );

endmodule

`default_nettype wire

// ==== dv/simd_alu_assert.sv ====
`timescale 1ns/100ps
`include "simd_alu_config.svh"
`default_nettype none

module simd_alu_assert (
    input wire logic                      clk,
    input wire logic                      rst_n,
    input wire logic                      alu,
    input wire logic [`SIMD_ALU_OP_W-1:0] alu_op,
    input wire logic [1:0]                width,
    input wire logic [`SIMD_ALU_XLEN-1:0] reg_a_data,
    input wire logic [`SIMD_ALU_XLEN-1:0] reg_b_data,
    input wire logic [`SIMD_ALU_XLEN-1:0] alu_out,
    input wire logic                      result_valid
);

    logic       fail_seen = 1'b0;   // polled by the bench
    logic [1:0] warm;               // saturating count of edges since reset release

    // ********************
    // reference model
    // ********************
    // lane i of width lw sits at bits [63-i*lw -: lw] with lane 0 at the msb end
    function automatic logic [63:0] ref_result(input logic [5:0] op, input logic [1:0] wc,
                                               input logic [63:0] a, input logic [63:0] b);
        int          lw;
        int          sh;
        int          lane;
        logic [63:0] mask;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] r;
        logic [63:0] res;
        lw   = 8 << wc;
        mask = (lw == 64) ? '1 : ((64'd1 << lw) - 64'd1);
        res  = '0;
        case (op)
            simd_alu_pkg::VAND: res = a & b;
            simd_alu_pkg::VOR:  res = a | b;
            simd_alu_pkg::VXOR: res = a ^ b;
            simd_alu_pkg::VNOT: res = ~a;
            simd_alu_pkg::VADD, simd_alu_pkg::VSUB, simd_alu_pkg::VSLL,
            simd_alu_pkg::VSRL, simd_alu_pkg::VRTTH: begin
                for (int i = 0; i < 64 / lw; i++) begin
                    sh = 64 - lw * (i + 1);
                    la = (a >> sh) & mask;
                    lb = (b >> sh) & mask;
                    case (op)
                        simd_alu_pkg::VADD: r = la + lb;
                        simd_alu_pkg::VSUB: r = la - lb;   // mask below wraps it
                        simd_alu_pkg::VSLL: r = la << (lb & (lw - 1));
                        simd_alu_pkg::VSRL: r = la >> (lb & (lw - 1));
                        default:            r = (la >> (lw / 2)) | (la << (lw / 2));
                    endcase
                    res = res | ((r & mask) << sh);
                end
            end
            simd_alu_pkg::VMULEU, simd_alu_pkg::VMULOU,
            simd_alu_pkg::VSQEU, simd_alu_pkg::VSQOU: begin
                if (wc != 2'b11) begin                 // no product slot at 11
                    for (int k = 0; k < 32 / lw; k++) begin
                        lane = 2 * k;
                        if (op == simd_alu_pkg::VMULOU || op == simd_alu_pkg::VSQOU) begin
                            lane = lane + 1;
                        end
                        sh = 64 - lw * (lane + 1);
                        la = (a >> sh) & mask;
                        lb = (b >> sh) & mask;
                        if (op == simd_alu_pkg::VSQEU || op == simd_alu_pkg::VSQOU) begin
                            lb = la;
                        end
                        res = res | ((la * lb) << (64 - 2 * lw * (k + 1)));   // slot k
                    end
                end
            end
            default: res = '0;                         // nop and holes
        endcase
        return res;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            warm <= '0;
        end else if (warm != 2'd3) begin
            warm <= warm + 2'd1;
        end
    end

    // ********************
    // checks
    // ********************
    // first edge after reset release
    a_reset_state: assert property (@(posedge clk)
        (rst_n && warm == 2'd0) |-> (!result_valid && alu_out == '0))
        else begin
            $error("FAIL %0t: outputs not cleared by reset, valid %b out %h",
                   $time, $sampled(result_valid), $sampled(alu_out));
            fail_seen = 1'b1;
        end

    // valid rises after the second edge past the sampled strobe
    a_valid_timing: assert property (@(posedge clk)
        (warm >= 2'd2) |-> (result_valid == $past(alu, 2)))
        else begin
            $error("FAIL %0t: result_valid %b but strobe two edges back was %b",
                   $time, $sampled(result_valid), $past(alu, 2));
            fail_seen = 1'b1;
        end

    a_result_value: assert property (@(posedge clk)
        (warm >= 2'd2 && result_valid) |-> (alu_out == ref_result($past(alu_op, 2),
            $past(width, 2), $past(reg_a_data, 2), $past(reg_b_data, 2))))
        else begin
            $error("FAIL %0t: op %0d width %0d gave %h, expected %h", $time,
                   $past(alu_op, 2), $past(width, 2), $sampled(alu_out),
                   ref_result($past(alu_op, 2), $past(width, 2),
                              $past(reg_a_data, 2), $past(reg_b_data, 2)));
            fail_seen = 1'b1;
        end

    a_hold_out: assert property (@(posedge clk)
        (warm >= 2'd1 && !result_valid) |-> $stable(alu_out))
        else begin
            $error("FAIL %0t: alu_out moved to %h while result_valid was low",
                   $time, $sampled(alu_out));
            fail_seen = 1'b1;
        end

endmodule

`default_nettype wire

// ==== dv/simd_alu_tb.sv ====
`timescale 1ns/100ps
`include "simd_alu_config.svh"
`default_nettype none

module simd_alu_tb;

    localparam int N_OPS  = 22;    // kept ops first, then holes
    localparam int N_KEPT = 14;
    localparam int N_RAND = 300;
    localparam int MAX_WAIT = 20;  // cycles allowed for the last result

    // opcode table, kept encodings then a spread of undefined ones
    localparam logic [5:0] OPS [N_OPS] = '{
        6'd1, 6'd2, 6'd3, 6'd4, 6'd6, 6'd7, 6'd8, 6'd9, 6'd16, 6'd17, 6'd10,
        6'd11, 6'd13, 6'd23, 6'd0, 6'd5, 6'd12, 6'd14, 6'd15, 6'd18, 6'd31, 6'd63
    };

    typedef struct packed {
        simd_alu_pkg::alu_op_e     op;
        simd_alu_pkg::lane_width_e width;
        logic [`SIMD_ALU_XLEN-1:0] a;
        logic [`SIMD_ALU_XLEN-1:0] b;
    } issue_t;

    logic                      clk;
    logic                      rst_n;
    logic                      alu;
    simd_alu_pkg::alu_op_e     alu_op;
    simd_alu_pkg::lane_width_e width;
    logic [`SIMD_ALU_XLEN-1:0] reg_a_data;
    logic [`SIMD_ALU_XLEN-1:0] reg_b_data;
    logic [`SIMD_ALU_XLEN-1:0] alu_out;
    logic                      result_valid;
    logic                      fail_seen;

    logic [31:0] lfsr_state = 32'h0d36ab4e;
    int          n_issued = 0;
    int          n_results = 0;

    simd_alu i_simd_alu (
        .clk(clk), .rst_n(rst_n), .alu(alu), .alu_op(alu_op), .width(width),
        .reg_a_data(reg_a_data), .reg_b_data(reg_b_data),
        .alu_out(alu_out), .result_valid(result_valid)
    );

    bind simd_alu simd_alu_assert i_simd_alu_assert (
        .clk(clk), .rst_n(rst_n), .alu(alu), .alu_op(alu_op), .width(width),
        .reg_a_data(reg_a_data), .reg_b_data(reg_b_data),
        .alu_out(alu_out), .result_valid(result_valid)
    );

    assign fail_seen = i_simd_alu.i_simd_alu_assert.fail_seen;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ********************
    // stimulus helpers
    // ********************
    // galois form, taps x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);   // one step per bit
        end
        return v;
    endfunction

    task automatic issue(input issue_t req);
        @(posedge clk);
        #1;
        alu        = 1'b1;
        alu_op     = req.op;
        width      = req.width;
        reg_a_data = req.a;
        reg_b_data = req.b;
        n_issued++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            alu = 1'b0;
        end
    endtask

    // mid-cycle, outputs settled
    always @(negedge clk) begin
        if (rst_n && result_valid) begin
            n_results++;
        end
        if (fail_seen) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "assertion failure reported by the checker");
        end
    end

    // ********************
    // main sequence
    // ********************
    initial begin
        issue_t req;
        int     sel;
        int     waited;
        alu        = 1'b0;
        alu_op     = simd_alu_pkg::VNOP;
        width      = simd_alu_pkg::LW_BYTE;
        reg_a_data = '0;
        reg_b_data = '0;
        rst_n      = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        idle(2);

        // every opcode at every width, back to back per opcode
        for (int i = 0; i < N_OPS; i++) begin
            for (int w = 0; w < 4; w++) begin
                req.op    = simd_alu_pkg::alu_op_e'(OPS[i]);
                req.width = simd_alu_pkg::lane_width_e'(w[1:0]);
                req.a     = take_bits(64);
                req.b     = take_bits(64);
                issue(req);
            end
            idle(int'(take_bits(2)));   // gap of 0 to 3
        end

        // all ones, which is also the max shift in every lane
        for (int i = 0; i < N_KEPT; i++) begin
            for (int w = 0; w < 4; w++) begin
                req.op    = simd_alu_pkg::alu_op_e'(OPS[i]);
                req.width = simd_alu_pkg::lane_width_e'(w[1:0]);
                req.a     = '1;
                req.b     = '1;
                issue(req);
            end
        end

        // zero shift amounts
        for (int w = 0; w < 4; w++) begin
            req.width = simd_alu_pkg::lane_width_e'(w[1:0]);
            req.a     = take_bits(64);
            req.b     = '0;
            req.op    = simd_alu_pkg::VSLL;
            issue(req);
            req.op    = simd_alu_pkg::VSRL;
            issue(req);
        end
        idle(3);

        // random mix with bursts and idle gaps
        for (int n = 0; n < N_RAND; n++) begin
            sel       = int'(take_bits(5)) % N_OPS;
            req.op    = simd_alu_pkg::alu_op_e'(OPS[sel]);
            req.width = simd_alu_pkg::lane_width_e'(take_bits(2));
            req.a     = take_bits(64);
            req.b     = take_bits(64);
            issue(req);
            if (take_bits(2) == 0) begin
                idle(1 + int'(take_bits(2)));
            end
        end
        idle(1);

        // drain, every issue owes one result
        waited = 0;
        while (n_results < n_issued && waited < MAX_WAIT) begin
            @(posedge clk);
            waited++;
        end
        if (n_results < n_issued) begin
            $display("timeout: no result_valid arrived for the last issued operation");
            $display("TEST RESULT: FAIL");
            $fatal(1, "pipeline did not drain");
        end else begin
            idle(4);   // quiet tail for the hold and valid checks
            if (fail_seen) begin
                $display("TEST RESULT: FAIL");
                $fatal(1, "assertion failure reported by the checker");
            end else begin
                $display("TEST RESULT: PASS");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+hw
hw/simd_alu_pkg.sv
hw/simd_alu_decode.sv
hw/simd_alu_lane_arith.sv
hw/simd_alu_lane_mul.sv
hw/simd_alu_shift_rot.sv
hw/simd_alu_result_sel.sv
hw/simd_alu.sv
dv/simd_alu_assert.sv
dv/simd_alu_tb.sv
